// ==== design/aes_pkg.sv ====
`default_nettype none

package aes_pkg;

  localparam int block_bits = 128;  // Block and key width
  localparam int word_bits  = 32;   // One column or key word
  localparam int num_rounds = 10;
  localparam int round_bits = 4;

  typedef logic [block_bits-1:0] aes_block_t;  // Byte 0 in the top bits
  typedef logic [word_bits-1:0]  aes_word_t;   // Row 0 in the top bits
  typedef logic [round_bits-1:0] aes_round_t;

  // Sequencer to datapath control
  typedef struct packed {
    logic       load;   // Accepted start this cycle
    logic       run;    // Round applied at the next edge
    logic       last;   // Round ten, no MixColumns
    aes_round_t round;
  } aes_ctrl_t;

  // --------------------------------------------------------------------------
  // Forward S-box, one row per high nibble
  // --------------------------------------------------------------------------
  localparam logic [127:0] sbox_rows [16] = '{
    128'h637c777b_f26b6fc5_3001672b_fed7ab76,
    128'hca82c97d_fa5947f0_add4a2af_9ca472c0,
    128'hb7fd9326_363ff7cc_34a5e5f1_71d83115,
    128'h04c723c3_1896059a_071280e2_eb27b275,
    128'h09832c1a_1b6e5aa0_523bd6b3_29e32f84,
    128'h53d100ed_20fcb15b_6acbbe39_4a4c58cf,
    128'hd0efaafb_434d3385_45f9027f_503c9fa8,
    128'h51a3408f_929d38f5_bcb6da21_10fff3d2,
    128'hcd0c13ec_5f974417_c4a77e3d_645d1973,
    128'h60814fdc_222a9088_46eeb814_de5e0bdb,
    128'he0323a0a_4906245c_c2d3ac62_9195e479,
    128'he7c8376d_8dd54ea9_6c56f4ea_657aae08,
    128'hba78252e_1ca6b4c6_e8dd741f_4bbd8b8a,
    128'h703eb566_4803f60e_613557b9_86c11d9e,
    128'he1f89811_69d98e94_9b1e87e9_ce5528df,
    128'h8ca1890d_bfe64268_41992d0f_b054bb16
  };

  function automatic logic [7:0] sub_byte(input logic [7:0] b);
    logic [127:0] row;
    row = sbox_rows[b[7:4]];
    return row[127 - 8*b[3:0] -: 8];  // Low nibble picks the column
  endfunction

  // Round constant, index 0 is the first expansion step
  function automatic logic [7:0] rcon(input aes_round_t idx);
    logic [7:0] rc;
    case (idx)
      4'd0:    rc = 8'h01;
      4'd1:    rc = 8'h02;
      4'd2:    rc = 8'h04;
      4'd3:    rc = 8'h08;
      4'd4:    rc = 8'h10;
      4'd5:    rc = 8'h20;
      4'd6:    rc = 8'h40;
      4'd7:    rc = 8'h80;
      4'd8:    rc = 8'h1b;
      4'd9:    rc = 8'h36;
      default: rc = 8'h00;  // Past the last useful key
    endcase
    return rc;
  endfunction

endpackage

`default_nettype wire

// ==== design/aes_mix_columns.sv ====
`timescale 1ns/1ps
`default_nettype none

module aes_mix_columns (
  input  aes_pkg::aes_word_t col_in,
  output aes_pkg::aes_word_t col_out
);

  logic [7:0] a0, a1, a2, a3;
  logic [7:0] sum;

  // Multiply by 2 in GF(2^8)
  function automatic logic [7:0] xtime(input logic [7:0] b);
    return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
  endfunction

  assign {a0, a1, a2, a3} = col_in;
  assign sum = a0 ^ a1 ^ a2 ^ a3;

  // Each row is 2*ai ^ 3*a(i+1) ^ a(i+2) ^ a(i+3), folded around the sum
  assign col_out = {
    a0 ^ sum ^ xtime(a0 ^ a1),
    a1 ^ sum ^ xtime(a1 ^ a2),
    a2 ^ sum ^ xtime(a2 ^ a3),
    a3 ^ sum ^ xtime(a3 ^ a0)
  };

endmodule

`default_nettype wire

// ==== design/aes_control.sv ====
`timescale 1ns/1ps
`default_nettype none

module aes_control (
  input  logic               clock,
  input  logic               resetn,
  input  logic               start,
  output aes_pkg::aes_ctrl_t ctrl,
  output logic               busy,
  output logic               text_val
);

  import aes_pkg::*;

  aes_round_t round_q;      // Round applied at the next edge, zero when idle
  logic       accept;
  logic       final_round;

  // Start while busy is dropped
  assign accept      = start & ~busy;
  assign final_round = busy && (round_q == aes_round_t'(num_rounds));

  always_comb begin
    ctrl.load  = accept;
    ctrl.run   = busy;
    ctrl.last  = final_round;
    ctrl.round = round_q;
  end

  // --------------------------------------------------------------------------
  // Round counter and status flags
  // --------------------------------------------------------------------------
  always_ff @(posedge clock or negedge resetn) begin
    if (!resetn) begin
      busy     <= 1'b0;
      text_val <= 1'b0;
      round_q  <= '0;
    end else begin
      text_val <= final_round;  // One cycle after round ten
      if (accept) begin
        busy    <= 1'b1;
        round_q <= aes_round_t'(1);
      end else if (final_round) begin
        busy    <= 1'b0;
        round_q <= '0;          // Idle again, ready for rcon index 0
      end else if (busy) begin
        round_q <= round_q + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== design/aes_key_expand.sv ====
`timescale 1ns/1ps
`default_nettype none

module aes_key_expand (
  input  logic                clock,
  input  logic                resetn,
  input  aes_pkg::aes_ctrl_t  ctrl,
  input  aes_pkg::aes_block_t key_in,
  output aes_pkg::aes_block_t round_key
);

  import aes_pkg::*;

  aes_block_t base_key;
  aes_block_t next_key;
  aes_word_t  rot_word;
  aes_word_t  temp;

  // Expand straight from the input key at load, so round key 1 is ready
  assign base_key = ctrl.load ? key_in : round_key;
  assign rot_word = {base_key[23:0], base_key[31:24]};

  always_comb begin
    temp = {sub_byte(rot_word[31:24]), sub_byte(rot_word[23:16]),
            sub_byte(rot_word[15:8]),  sub_byte(rot_word[7:0])};
    temp[31:24] = temp[31:24] ^ rcon(ctrl.round);

    // Chained word xors
    next_key[127:96] = base_key[127:96] ^ temp;
    next_key[95:64]  = base_key[95:64]  ^ next_key[127:96];
    next_key[63:32]  = base_key[63:32]  ^ next_key[95:64];
    next_key[31:0]   = base_key[31:0]   ^ next_key[63:32];
  end

  always_ff @(posedge clock or negedge resetn) begin
    if (!resetn) begin
      round_key <= '0;
    end else if (ctrl.load || ctrl.run) begin
      round_key <= next_key;
    end
  end

endmodule

`default_nettype wire

// ==== design/aes_round.sv ====
`timescale 1ns/1ps
`default_nettype none

module aes_round (
  input  logic                clock,
  input  logic                resetn,
  input  aes_pkg::aes_ctrl_t  ctrl,
  input  aes_pkg::aes_block_t text_in,
  input  aes_pkg::aes_block_t key_in,
  input  aes_pkg::aes_block_t round_key,
  output aes_pkg::aes_block_t state
);

  import aes_pkg::*;

  aes_word_t  shifted [4];  // After SubBytes and ShiftRows
  aes_word_t  mixed   [4];
  aes_block_t round_out;

  // --------------------------------------------------------------------------
  // SubBytes and ShiftRows
  // --------------------------------------------------------------------------
  // Row r of column c comes from column c+r
  always_comb begin
    for (int c = 0; c < 4; c++) begin
      for (int r = 0; r < 4; r++) begin
        shifted[c][31 - 8*r -: 8] = sub_byte(state[127 - 32*((c + r) % 4) - 8*r -: 8]);
      end
    end
  end

  // --------------------------------------------------------------------------
  // MixColumns
  // --------------------------------------------------------------------------
  for (genvar c = 0; c < 4; c++) begin : g_col
    aes_mix_columns i_mix_columns (
      .col_in  (shifted[c]),
      .col_out (mixed[c])
    );
  end

  // AddRoundKey, final round skips the mix
  always_comb begin
    for (int c = 0; c < 4; c++) begin
      round_out[127 - 32*c -: 32] = (ctrl.last ? shifted[c] : mixed[c])
                                    ^ round_key[127 - 32*c -: 32];
    end
  end

  // --------------------------------------------------------------------------
  // State register
  // --------------------------------------------------------------------------
  always_ff @(posedge clock or negedge resetn) begin
    if (!resetn) begin
      state <= '0;
    end else if (ctrl.load) begin
      state <= text_in ^ key_in;  // Initial key addition
    end else if (ctrl.run) begin
      state <= round_out;
    end
  end

endmodule

`default_nettype wire

// ==== design/aes128_ecb.sv ====
`timescale 1ns/1ps
`default_nettype none

module aes128_ecb (
  input  logic                clock,
  input  logic                resetn,
  input  logic                start,
  input  aes_pkg::aes_block_t key_in,
  input  aes_pkg::aes_block_t text_in,
  output logic                busy,
  output logic                text_val,
  output aes_pkg::aes_block_t text_out
);

  import aes_pkg::*;

  aes_ctrl_t  ctrl;
  aes_block_t round_key;

  aes_control i_aes_control (
    .clock    (clock),
    .resetn   (resetn),
    .start    (start),
    .ctrl     (ctrl),
    .busy     (busy),
    .text_val (text_val)
  );

  // Round keys generated one step ahead of the datapath
  aes_key_expand i_aes_key_expand (
    .clock     (clock),
    .resetn    (resetn),
    .ctrl      (ctrl),
    .key_in    (key_in),
    .round_key (round_key)
  );

  aes_round i_aes_round (
    .clock     (clock),
    .resetn    (resetn),
    .ctrl      (ctrl),
    .text_in   (text_in),
    .key_in    (key_in),
    .round_key (round_key),
    .state     (text_out)    // Ciphertext held until the next start
  );

endmodule

`default_nettype wire

// ==== dv/aes_ref.svh ====
`ifndef AES_REF_SVH
`define AES_REF_SVH

// Product in GF(2^8) modulo x^8 + x^4 + x^3 + x + 1
function automatic logic [7:0] gf_mul(input logic [7:0] a, input logic [7:0] b);
  logic [7:0] p;
  logic [7:0] x;
  p = 8'h00;
  x = a;
  for (int i = 0; i < 8; i++) begin
    if (b[i]) begin
      p = p ^ x;
    end
    x = {x[6:0], 1'b0} ^ (x[7] ? 8'h1b : 8'h00);
  end
  return p;
endfunction

// S-box from the field inverse (b^254) and the affine transform
function automatic logic [7:0] forward_sbox(input logic [7:0] b);
  logic [7:0] sq;
  logic [7:0] inv;
  sq  = b;
  inv = 8'h01;
  for (int k = 1; k < 8; k++) begin
    sq  = gf_mul(sq, sq);
    inv = gf_mul(inv, sq);
  end
  return inv ^ {inv[6:0], inv[7]} ^ {inv[5:0], inv[7:6]} ^ {inv[4:0], inv[7:5]}
         ^ {inv[3:0], inv[7:4]} ^ 8'h63;
endfunction

// Full AES-128 encryption, byte i of a block sits at bits 127-8*i
function automatic logic [127:0] encrypt_block(input logic [127:0] key,
                                               input logic [127:0] pt);
  logic [31:0]  w [44];
  logic [7:0]   s [16];
  logic [7:0]   t [16];
  logic [31:0]  tmp;
  logic [7:0]   rc;
  logic [127:0] ct;
  for (int i = 0; i < 4; i++) begin
    w[i] = key[127 - 32*i -: 32];
  end
  rc = 8'h01;
  for (int i = 4; i < 44; i++) begin
    tmp = w[i-1];
    if (i % 4 == 0) begin
      tmp = {forward_sbox(tmp[23:16]), forward_sbox(tmp[15:8]),
             forward_sbox(tmp[7:0]),   forward_sbox(tmp[31:24])};
      tmp[31:24] ^= rc;
      rc = gf_mul(rc, 8'h02);
    end
    w[i] = w[i-4] ^ tmp;
  end
  for (int i = 0; i < 16; i++) begin
    s[i] = pt[127 - 8*i -: 8] ^ key[127 - 8*i -: 8];
  end
  for (int rnd = 1; rnd <= 10; rnd++) begin
    for (int c = 0; c < 4; c++) begin
      for (int r = 0; r < 4; r++) begin
        t[4*c + r] = forward_sbox(s[4*((c + r) % 4) + r]);  // SubBytes, ShiftRows
      end
    end
    for (int c = 0; c < 4; c++) begin
      for (int r = 0; r < 4; r++) begin
        if (rnd < 10) begin
          s[4*c + r] = gf_mul(t[4*c + r], 8'h02) ^ gf_mul(t[4*c + (r+1)%4], 8'h03)
                       ^ t[4*c + (r+2)%4] ^ t[4*c + (r+3)%4];
        end else begin
          s[4*c + r] = t[4*c + r];
        end
        s[4*c + r] ^= w[4*rnd + c][31 - 8*r -: 8];
      end
    end
  end
  for (int i = 0; i < 16; i++) begin
    ct[127 - 8*i -: 8] = s[i];
  end
  return ct;
endfunction

`endif

// ==== dv/aes128_ecb_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module aes128_ecb_tb;

  import aes_pkg::*;

  `include "aes_ref.svh"

  localparam int num_random     = 30;
  localparam int num_ops        = num_random + 3;
  localparam int timeout_cycles = num_ops * 12 + 50;

  logic       clock;
  logic       resetn;
  logic       start;
  aes_block_t key_in;
  aes_block_t text_in;
  logic       busy;
  logic       text_val;
  aes_block_t text_out;

  // Expected behavior, rebuilt from the start pulses
  int         cycles_left;
  logic       exp_val;
  aes_block_t exp_text;
  aes_block_t exp_hold;   // What text_out shows while idle
  logic       exp_busy;

  aes128_ecb i_aes128_ecb (
    .clock    (clock),
    .resetn   (resetn),
    .start    (start),
    .key_in   (key_in),
    .text_in  (text_in),
    .busy     (busy),
    .text_val (text_val),
    .text_out (text_out)
  );

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Some tests failed");
    $fatal(1, "stopped at the first error");
  endtask

  function automatic aes_block_t random_block();
    return {$urandom, $urandom, $urandom, $urandom};
  endfunction

  // --------------------------------------------------------------------------
  // Reference timing model and checks
  // --------------------------------------------------------------------------
  assign exp_busy = (cycles_left != 0);

  always @(posedge clock or negedge resetn) begin
    if (!resetn) begin
      cycles_left <= 0;
      exp_val     <= 1'b0;
      exp_text    <= '0;
      exp_hold    <= '0;
    end else begin
      exp_val <= (cycles_left == 1);  // Result one edge after round ten
      if (cycles_left == 1) begin
        exp_hold <= exp_text;
      end
      if (start && cycles_left == 0) begin
        cycles_left <= num_rounds;
        exp_text    <= encrypt_block(key_in, text_in);
      end else if (cycles_left != 0) begin
        cycles_left <= cycles_left - 1;
      end
    end
  end

  // Outputs are stable at the falling edge
  always @(negedge clock) begin
    if (resetn) begin
      assert (busy == exp_busy)
        else report_failure($sformatf("error busy expected %h actual %h", exp_busy, busy));
      assert (text_val == exp_val)
        else report_failure($sformatf("error text_val expected %h actual %h",
                                      exp_val, text_val));
      if (text_val) begin
        assert (text_out == exp_text)
          else report_failure($sformatf("error text_out expected %h actual %h",
                                        exp_text, text_out));
      end
      if (!exp_busy) begin
        assert (text_out == exp_hold)  // Held through idle cycles
          else report_failure($sformatf("error text_out expected %h actual %h",
                                        exp_hold, text_out));
      end
    end
  end

  assert property (@(posedge clock) disable iff (!resetn) text_val |=> !text_val)
    else report_failure("text_val stayed high for more than one cycle");

  assert property (@(posedge clock) disable iff (!resetn) $fell(busy) |-> text_val)
    else report_failure("busy fell without a result on text_val");

  // --------------------------------------------------------------------------
  // Stimulus
  // --------------------------------------------------------------------------
  // Called at a falling edge with the core idle, returns while text_val is high
  task automatic run_block(input aes_block_t key, input aes_block_t pt, input bit disturb);
    start   = 1'b1;
    key_in  = key;
    text_in = pt;
    @(negedge clock);
    start   = 1'b0;
    key_in  = random_block();  // Inputs need not be held
    text_in = random_block();
    if (disturb) begin
      repeat (4) @(negedge clock);
      start   = 1'b1;          // Ignored while busy
      key_in  = random_block();
      text_in = random_block();
      @(negedge clock);
      start   = 1'b0;
    end
    while (!text_val) begin
      @(negedge clock);
    end
  endtask

  initial begin
    void'($urandom(32'h003a_07c6));
    resetn  = 1'b0;
    start   = 1'b0;
    key_in  = '0;
    text_in = '0;
    repeat (2) @(posedge clock);
    @(negedge clock);
    resetn = 1'b1;
    repeat (3) @(negedge clock);

    run_block(128'h000102030405060708090a0b0c0d0e0f,
              128'h00112233445566778899aabbccddeeff, 1'b0);
    assert (text_out == 128'h69c4e0d86a7b0430d8cdb78070b4c55a)
      else report_failure($sformatf("error text_out expected %h actual %h",
                                    128'h69c4e0d86a7b0430d8cdb78070b4c55a, text_out));

    for (int i = 0; i < num_random; i++) begin
      run_block(random_block(), random_block(), 1'b0);  // Back to back
    end

    run_block(random_block(), random_block(), 1'b1);
    repeat (6) @(negedge clock);  // No extra pulse, result holds

    $display("All tests passed");
    $finish;
  end

  initial begin
    repeat (timeout_cycles) @(posedge clock);
    report_failure("timeout, the run did not complete in time");
  end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+dv
design/aes_pkg.sv
design/aes_mix_columns.sv
design/aes_control.sv
design/aes_key_expand.sv
design/aes_round.sv
design/aes128_ecb.sv
dv/aes128_ecb_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the AES-128 testbench with Verilator

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
  echo "cannot enter the project directory"
  exit 1
fi

verilator --binary --timing --assert -Wno-fatal -f flist.f \
  --top-module aes128_ecb_tb -Mdir obj_dir -o aes128_ecb_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/aes128_ecb_sim
status=$?
if [ $status -ne 0 ]; then
  echo "simulation failed with status $status"
fi
exit $status
